//--- src/train_pkg.sv
package train_pkg;

  // ------------------------------
  // fixed-point format, Q4.12
  // ------------------------------
  localparam int N_LEN     = 16;
  localparam int FRAC_BITS = 12;

  // 1.0 in Q4.12
  localparam int ONE       = 4096;

  // ------------------------------
  // matrix sizes
  // ------------------------------
  // hidden side must stay even, columns are summed in pairs
  localparam int HID_DIM    = 4;

  // rows coming out of the dense layer
  localparam int N          = 2;

  localparam int PAIR_STEPS = HID_DIM / 2;

  // column counter, wide enough to hold HID_DIM
  localparam int CNT_W      = $clog2(HID_DIM + 1);

  // ------------------------------
  // data types
  // ------------------------------
  typedef logic signed [N_LEN-1:0] num_t;

  typedef num_t [HID_DIM-1:0] hid_row_t;

  // [i][j] is row i, column j
  typedef hid_row_t [HID_DIM-1:0] hid_mat_t;

  typedef hid_row_t [N-1:0] dense_mat_t;

  // backward phases, B_IDLE between runs
  typedef enum logic [1:0] {
    B_IDLE,
    B_TANH3,
    B_TANH2,
    B_TANH1
  } bwd_state_t;

  // one work item for the derivative pipeline
  typedef struct packed {
    hid_mat_t   grad;
    hid_mat_t   act;
    bwd_state_t layer;
  } tanh_pair_t;

  // forward activations of the three tanh layers
  typedef struct packed {
    hid_mat_t act3;
    hid_mat_t act2;
    hid_mat_t act1;
  } act_set_t;

  // fixed-point product, arithmetic shift then wrap to 16 bits
  function automatic num_t fx_mul(input num_t a, input num_t b);
    logic signed [2*N_LEN-1:0] prod;
    prod = a * b;
    return num_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

//--- src/backward_ctrl.sv
module backward_ctrl import train_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  output bwd_state_t       state,
  output logic [CNT_W-1:0] count,
  output logic             busy,
  output logic             done
);

  // high in the first idle cycle after a run
  logic tail;

  logic last_pair;

  assign last_pair = (count == CNT_W'(HID_DIM - 2));

  // ------------------------------
  // phase sequencer
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= B_IDLE;
      count <= '0;
    end else begin
      case (state)
        B_IDLE: begin
          // start is only looked at here, so a pulse during a run is dropped
          if (start) begin
            state <= B_TANH3;
          end
        end
        B_TANH3: begin
          state <= B_TANH2;
          count <= '0;
        end
        B_TANH2: begin
          if (last_pair) begin
            state <= B_TANH1;
            count <= '0;
          end else begin
            count <= count + CNT_W'(2);
          end
        end
        B_TANH1: begin
          state <= B_IDLE;
        end
        default: begin
          state <= B_IDLE;
          count <= '0;
        end
      endcase
    end
  end

  assign busy = (state != B_IDLE);

  // ------------------------------
  // done strobe
  // ------------------------------
  // one cycle after the return to idle, so done lines up with the
  // row-sum result leaving the derivative pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail <= 1'b0;
      done <= 1'b0;
    end else begin
      tail <= (state == B_TANH1);
      done <= tail;
    end
  end

endmodule

//--- src/backward_tanh_input.sv
module backward_tanh_input import train_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  bwd_state_t       state,
  input  logic [CNT_W-1:0] count,
  input  dense_mat_t       d_dense,
  input  hid_mat_t         d_mix,
  input  act_set_t         acts,
  output tanh_pair_t       pair,
  output logic             pair_valid
);

  // per-row running sums for the B_TANH2 phase
  hid_row_t acc;

  // running sum plus the current column pair
  hid_row_t row_sum;

  hid_mat_t grad_next;
  hid_mat_t act_next;
  logic     last_pair;
  logic     load;

  assign last_pair = (state == B_TANH2) && (count == CNT_W'(HID_DIM - 2));

  assign load = (state == B_TANH3) || last_pair || (state == B_TANH1);

  // ------------------------------
  // row-sum accumulation
  // ------------------------------
  always_comb begin
    for (int i = 0; i < HID_DIM; i++) begin
      row_sum[i] = d_mix[i][count] + d_mix[i][count + 1];
      // count 0 starts a fresh sum
      if (count != '0) begin
        row_sum[i] = row_sum[i] + acc[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == B_TANH2) begin
      acc <= row_sum;
    end
  end

  // ------------------------------
  // gradient shaping per phase
  // ------------------------------
  always_comb begin
    grad_next = '0;
    act_next  = acts.act3;
    case (state)
      B_TANH3: begin
        // dense rows on top, zero padding below
        for (int i = 0; i < N; i++) begin
          grad_next[i] = d_dense[i];
        end
        act_next = acts.act3;
      end
      B_TANH2: begin
        // sums land in column 0
        for (int i = 0; i < HID_DIM; i++) begin
          grad_next[i][0] = row_sum[i];
        end
        act_next = acts.act2;
      end
      B_TANH1: begin
        grad_next = d_mix;
        act_next  = acts.act1;
      end
      default: begin
        grad_next = '0;
      end
    endcase
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pair <= '{grad: grad_next, act: act_next, layer: state};
    end
  end

endmodule

//--- src/backward_tanh.sv
module backward_tanh import train_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  tanh_pair_t pair,
  input  logic       pair_valid,
  output hid_mat_t   q,
  output bwd_state_t q_layer,
  output logic       q_valid
);

  hid_mat_t   s1_grad;
  hid_mat_t   s1_deriv;
  bwd_state_t s1_layer;
  logic       s1_valid;

  hid_mat_t   deriv;
  hid_mat_t   prod;

  // ------------------------------
  // stage 1, 1 - act^2
  // ------------------------------
  always_comb begin
    for (int i = 0; i < HID_DIM; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        deriv[i][j] = num_t'(ONE) - fx_mul(pair.act[i][j], pair.act[i][j]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pair_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pair_valid) begin
      s1_grad  <= pair.grad;
      s1_deriv <= deriv;
      s1_layer <= pair.layer;
    end
  end

  // ------------------------------
  // stage 2, grad * derivative
  // ------------------------------
  always_comb begin
    for (int i = 0; i < HID_DIM; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        prod[i][j] = fx_mul(s1_grad[i][j], s1_deriv[i][j]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= s1_valid;
    end
  end

  // each stage holds its own item, so two results can be in flight
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      q       <= prod;
      q_layer <= s1_layer;
    end
  end

endmodule

//--- src/backward_tanh_top.sv
module backward_tanh_top import train_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  dense_mat_t d_dense,
  input  hid_mat_t   d_mix,
  input  act_set_t   acts,
  output hid_mat_t   q,
  output bwd_state_t q_layer,
  output logic       q_valid,
  output logic       busy,
  output logic       done
);

  bwd_state_t       state;
  logic [CNT_W-1:0] count;
  tanh_pair_t       pair;
  logic             pair_valid;

  // ------------------------------
  // sequencer
  // ------------------------------
  backward_ctrl u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .state (state),
    .count (count),
    .busy  (busy),
    .done  (done)
  );

  // ------------------------------
  // gradient shaping
  // ------------------------------
  backward_tanh_input u_input (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .count      (count),
    .d_dense    (d_dense),
    .d_mix      (d_mix),
    .acts       (acts),
    .pair       (pair),
    .pair_valid (pair_valid)
  );

  // derivative pipeline, 2 cycles
  backward_tanh u_tanh (
    .clk        (clk),
    .rst_n      (rst_n),
    .pair       (pair),
    .pair_valid (pair_valid),
    .q          (q),
    .q_layer    (q_layer),
    .q_valid    (q_valid)
  );

endmodule

//--- test/tb_backward_tanh_top.sv
module tb_backward_tanh_top import train_pkg::*; ();

  localparam int NUM_RUNS = 12;
  localparam int TIMEOUT  = NUM_RUNS * (PAIR_STEPS + 12) + 40;

  logic       clk;
  logic       rst_n;
  logic       start;
  dense_mat_t d_dense;
  hid_mat_t   d_mix;
  act_set_t   acts;
  hid_mat_t   q;
  bwd_state_t q_layer;
  logic       q_valid;
  logic       busy;
  logic       done;

  integer seed;
  int     cycle     = 0;
  int     done_at   = -1;
  int     err_value = 0;
  int     err_proto = 0;

  // expected results, oldest first
  hid_mat_t   exp_mat[$];
  bwd_state_t exp_layer[$];
  int         exp_cycle[$];
  int         exp_run[$];

  backward_tanh_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .d_dense (d_dense),
    .d_mix   (d_mix),
    .acts    (acts),
    .q       (q),
    .q_layer (q_layer),
    .q_valid (q_valid),
    .busy    (busy),
    .done    (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT) begin
      $display("timeout: no end of test within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // Q4.12 product, keep bits above the fraction and wrap to 16
  function automatic num_t q_mult(input num_t a, input num_t b);
    logic signed [31:0] full;
    full = a * b;
    return full[FRAC_BITS+N_LEN-1:FRAC_BITS];
  endfunction

  function automatic hid_mat_t scale_by_deriv(input hid_mat_t g, input hid_mat_t a);
    hid_mat_t r;
    num_t     d;
    for (int i = 0; i < HID_DIM; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        d = num_t'(ONE) - q_mult(a[i][j], a[i][j]);
        r[i][j] = q_mult(g[i][j], d);
      end
    end
    return r;
  endfunction

  task automatic push_result(input int run, input hid_mat_t m, input bwd_state_t l,
                             input int at);
    exp_mat.push_back(m);
    exp_layer.push_back(l);
    exp_cycle.push_back(at);
    exp_run.push_back(run);
  endtask

  // s is the cycle count seen just after the edge that samples start
  task automatic push_expect(input int run, input int s);
    hid_mat_t g3;
    hid_mat_t g2;
    num_t     sum;
    g3 = '0;
    g2 = '0;
    for (int i = 0; i < N; i++) begin
      g3[i] = d_dense[i];
    end
    for (int i = 0; i < HID_DIM; i++) begin
      sum = '0;
      for (int j = 0; j < HID_DIM; j++) begin
        sum = sum + d_mix[i][j];
      end
      g2[i][0] = sum;
    end
    push_result(run, scale_by_deriv(g3, acts.act3), B_TANH3, s + 3);
    push_result(run, scale_by_deriv(g2, acts.act2), B_TANH2, s + 3 + PAIR_STEPS);
    push_result(run, scale_by_deriv(d_mix, acts.act1), B_TANH1, s + 4 + PAIR_STEPS);
    done_at = s + 3 + PAIR_STEPS;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_mat(input string tname, input hid_mat_t exp, input hid_mat_t act);
    if (act !== exp) begin
      $display("[ERROR] %s q: expected %h, actual %h", tname, exp, act);
      err_value++;
    end
  endtask

  task automatic check_layer(input string tname, input bwd_state_t exp,
                             input bwd_state_t act);
    if (act !== exp) begin
      $display("[ERROR] %s q_layer: expected %s, actual %s", tname, exp.name(), act.name());
      err_value++;
    end
  endtask

  task automatic check_quiet(input string when);
    if (q_valid !== 1'b0 || busy !== 1'b0 || done !== 1'b0) begin
      $display("outputs not low %s: q_valid=%b busy=%b done=%b", when, q_valid, busy, done);
      err_proto++;
    end
  endtask

  // ------------------------------
  // monitor
  // ------------------------------
  always @(negedge clk) begin
    string tname;
    if (rst_n) begin
      if (q_valid) begin
        if (exp_layer.size() == 0) begin
          $display("q_valid with no result expected at cycle %0d", cycle);
          err_proto++;
        end else begin
          tname = $sformatf("run %0d %s", exp_run[0], exp_layer[0].name());
          if (cycle != exp_cycle[0]) begin
            $display("%s arrived at cycle %0d, expected at %0d", tname, cycle, exp_cycle[0]);
            err_proto++;
          end
          check_layer(tname, exp_layer[0], q_layer);
          check_mat(tname, exp_mat[0], q);
          void'(exp_mat.pop_front());
          void'(exp_layer.pop_front());
          void'(exp_cycle.pop_front());
          void'(exp_run.pop_front());
        end
      end else if (exp_layer.size() != 0 && cycle > exp_cycle[0]) begin
        $display("run %0d %s result did not arrive by cycle %0d",
                 exp_run[0], exp_layer[0].name(), exp_cycle[0]);
        err_proto++;
        void'(exp_mat.pop_front());
        void'(exp_layer.pop_front());
        void'(exp_cycle.pop_front());
        void'(exp_run.pop_front());
      end
      if (done) begin
        if (cycle != done_at) begin
          $display("done at cycle %0d, expected at %0d", cycle, done_at);
          err_proto++;
        end
        // only the B_TANH1 result may still be pending here
        if (exp_layer.size() != 1) begin
          $display("results missing at done, %0d still queued", exp_layer.size());
          err_proto++;
        end
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic fill_inputs();
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        d_dense[i][j] = num_t'($random(seed));
      end
    end
    for (int i = 0; i < HID_DIM; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        d_mix[i][j] = num_t'($random(seed));
        // activations stay strictly inside (-1, 1)
        acts.act3[i][j] = num_t'($random(seed) % ONE);
        acts.act2[i][j] = num_t'($random(seed) % ONE);
        acts.act1[i][j] = num_t'($random(seed) % ONE);
      end
    end
  endtask

  // entered and left just after a rising edge
  task automatic run_once(input int run);
    int s;
    fill_inputs();
    start = 1'b1;
    s = cycle + 1;
    push_expect(run, s);
    @(posedge clk);
    #1;
    start = 1'b0;
    @(posedge clk);
    #1;
    if (busy !== 1'b1) begin
      $display("busy low during run %0d", run);
      err_proto++;
    end
    // extra start while busy, must not add results
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    do @(negedge clk); while (done !== 1'b1);
    @(posedge clk);
    #1;
  endtask

  initial begin
    seed    = 84;
    rst_n   = 1'b0;
    start   = 1'b0;
    d_dense = '0;
    d_mix   = '0;
    acts    = '0;
    repeat (10) begin
      @(posedge clk);
      #1;
      check_quiet("during reset");
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_quiet("one cycle after reset");
    for (int r = 0; r < NUM_RUNS; r++) begin
      run_once(r);
    end
    while (exp_layer.size() != 0) begin
      @(negedge clk);
    end
    // catch stray results after the last run
    repeat (4) @(negedge clk);
    $display("error counts: %0d value, %0d protocol", err_value, err_proto);
    if (err_value + err_proto == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
src/train_pkg.sv
src/backward_ctrl.sv
src/backward_tanh_input.sv
src/backward_tanh.sv
src/backward_tanh_top.sv
test/tb_backward_tanh_top.sv
